// File: vlog.f
+incdir+common
common/cache_pkg.sv
common/lease_pkg.sv
common/mem_xfer_if.sv
common/lease_if.sv
lease/lease_lookup_table.sv
lease/lease_policy.sv
cache_ctrl/cache_store.sv
cache_ctrl/cache_controller.sv
src/wb_block_master.sv
src/lease_cache_top.sv
tests/lease_cache_tb.sv

// File: Bender.yml
package:
  name: lease_cache

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/cache_pkg.sv
      - common/lease_pkg.sv
      - common/mem_xfer_if.sv
      - common/lease_if.sv
      - lease/lease_lookup_table.sv
      - lease/lease_policy.sv
      - cache_ctrl/cache_store.sv
      - cache_ctrl/cache_controller.sv
      - src/wb_block_master.sv
      - src/lease_cache_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/lease_cache_tb.sv

// File: tests/lease_cache_tb.sv
`timescale 1ns/100ps
`include "lease_cache_settings.svh"

module lease_cache_tb import cache_pkg::*; import lease_pkg::*; ();

	localparam int NUM_REQ   = 21;
	localparam int NUM_LLT   = 6;
	localparam int TIMEOUT   = 200;   // cycles per request
	localparam int MEM_WORDS = 2**`LC_ADDR_W;

	typedef struct packed {
		logic                  we;
		word_addr_t            addr;
		logic [`LC_DATA_W-1:0] wdata;
	} req_t;

	logic                  clock_i;
	logic                  resetn_i;
	logic                  core_req_i;
	logic                  core_we_i;
	word_addr_t            core_addr_i;
	logic [`LC_DATA_W-1:0] core_wdata_i;
	logic [`LC_DATA_W-1:0] core_rdata_o;
	logic                  core_done_o;
	logic                  core_hit_o;
	logic                  llt_wren_i;
	llt_index_t            llt_index_i;
	llt_entry_t            llt_entry_i;
	logic                  wb_cyc_o;
	logic                  wb_stb_o;
	logic                  wb_we_o;
	word_addr_t            wb_adr_o;
	logic [`LC_DATA_W-1:0] wb_dat_o;
	logic [`LC_DATA_W-1:0] wb_dat_i = '0;
	logic                  wb_ack_i = 1'b0;
	logic                  flag_hit_o;
	logic                  flag_miss_o;
	logic                  flag_writeback_o;
	logic                  flag_swap_o;

	// lease table, set 1 blocks A B C D Z plus E in set 2
	llt_entry_t llt_tbl [NUM_LLT] = '{
		{14'h0009, 8'd2},   // A  0x0024
		{14'h0011, 8'd3},   // B  0x0044
		{14'h0019, 8'd1},   // C  0x0064
		{14'h0021, 8'd4},   // D  0x0084
		{14'h0029, 8'd0},   // Z, listed with lease zero
		{14'h003a, 8'd5}    // E  0x00e8
	};

	// we, addr, wdata
	req_t stim [NUM_REQ] = '{
		{1'b0, 16'h00e9, 32'h0},            // E miss, fill
		{1'b0, 16'h00e9, 32'h0},            // E hit
		{1'b0, 16'h00eb, 32'h0},            // E hit, other word
		{1'b0, 16'h00c4, 32'h0},            // not in table
		{1'b0, 16'h00c4, 32'h0},            // misses again
		{1'b0, 16'h00a5, 32'h0},            // lease zero
		{1'b1, 16'h00c6, 32'hcafe_0006},    // bypassed store
		{1'b0, 16'h00c6, 32'h0},            // read it back
		{1'b1, 16'h0026, 32'h1234_0026},    // A store miss
		{1'b1, 16'h0024, 32'h1234_0024},    // A store hit
		{1'b0, 16'h0045, 32'h0},            // B into the free way
		{1'b0, 16'h0064, 32'h0},            // C evicts dirty A
		{1'b0, 16'h0046, 32'h0},            // B hit
		{1'b0, 16'h0087, 32'h0},            // D
		{1'b0, 16'h0064, 32'h0},            // C, shorter lease loses
		{1'b0, 16'h0087, 32'h0},            // D should survive
		{1'b0, 16'h0045, 32'h0},            // B refetched
		{1'b1, 16'h0045, 32'h5678_0045},    // B store hit
		{1'b0, 16'h0026, 32'h0},            // A back from memory
		{1'b0, 16'h0067, 32'h0},            // C, equal leases
		{1'b0, 16'h0045, 32'h0}             // B still dirty
	};

	// memory and reference state
	logic [`LC_DATA_W-1:0] slave_mem [MEM_WORDS];
	logic [`LC_DATA_W-1:0] ref_mem   [MEM_WORDS];   // memory as the model sees it
	logic                  m_valid   [`LC_SETS][`LC_WAYS];
	logic                  m_dirty   [`LC_SETS][`LC_WAYS];
	tag_t                  m_tag     [`LC_SETS][`LC_WAYS];
	lease_t                m_lease   [`LC_SETS][`LC_WAYS];
	logic [`LC_DATA_W-1:0] m_line    [`LC_SETS][`LC_WAYS][`LC_BLOCK_WORDS];

	word_addr_t            exp_wr_addr [$];
	logic [`LC_DATA_W-1:0] exp_wr_data [$];
	word_addr_t            obs_wr_addr [$];
	logic [`LC_DATA_W-1:0] obs_wr_data [$];

	logic                  exp_hit;
	logic                  exp_wb;
	logic                  exp_swap;
	logic [`LC_DATA_W-1:0] exp_rdata;
	int                    exp_acks;
	int                    exp_cycles;

	int   wait_tbl [256];   // ack delays
	int   wait_idx = 0;
	int   ack_wait = 0;
	int   n_acks;
	int   n_cycles;
	logic cyc_q;
	int   cur_req;
	int   mismatches = 0;
	int   timeouts = 0;

	lease_cache_top i_dut (.*);

	initial begin
		clock_i = 1'b0;
		forever #20 clock_i = ~clock_i;
	end

	// wishbone slave
	// ----------------------------------------
	always @(posedge clock_i) begin
		if (!resetn_i) begin
			wb_ack_i <= 1'b0;
			cyc_q    <= 1'b0;
		end else begin
			cyc_q <= wb_cyc_o;
			if (wb_cyc_o && !cyc_q)
				n_cycles++;   // new bus cycle
			if (wb_ack_i)
				wb_ack_i <= 1'b0;   // master drops stb here
			else if (wb_stb_o && ack_wait != 0)
				ack_wait--;
			else if (wb_stb_o) begin
				wb_ack_i <= 1'b1;
				n_acks++;
				ack_wait = wait_tbl[wait_idx % 256];
				wait_idx++;
				if (wb_we_o) begin
					slave_mem[wb_adr_o] = wb_dat_o;
					obs_wr_addr.push_back(wb_adr_o);
					obs_wr_data.push_back(wb_dat_o);
				end else
					wb_dat_i <= slave_mem[wb_adr_o];
			end
		end
	end

	// whole address in both halves
	function automatic logic [`LC_DATA_W-1:0] fill_word(word_addr_t a);
		return {a ^ 16'h9e37, a};
	endfunction

	function automatic lease_t table_lease(block_addr_t blk);
		lease_t l;
		l = '0;
		for (int i = NUM_LLT-1; i >= 0; i--)   // lowest entry wins
			if (llt_tbl[i].block_addr == blk)
				l = llt_tbl[i].lease;
		return l;
	endfunction

	// reference model
	// ----------------------------------------
	task automatic predict(input req_t r);
		tag_t       t;
		set_t       s;
		offset_t    o;
		lease_t     l;
		way_t       v;
		way_t       hw;
		logic       in_line;
		word_addr_t a;
		{t, s, o} = r.addr;
		l = table_lease({t, s});
		in_line = 1'b0;
		hw = 1'b0;
		for (int w = 0; w < `LC_WAYS; w++) begin
			if (m_valid[s][w] && m_tag[s][w] == t) begin
				in_line = 1'b1;
				hw = way_t'(w);
			end
		end
		exp_hit = in_line;
		exp_wb = 1'b0;
		exp_swap = 1'b0;
		exp_rdata = '0;
		exp_acks = 0;
		exp_cycles = 0;
		for (int w = 0; w < `LC_WAYS; w++)   // age the set, hit line excepted
			if ((!in_line || way_t'(w) != hw) && m_lease[s][w] != '0)
				m_lease[s][w] = m_lease[s][w] - 1'b1;
		if (in_line)
			m_lease[s][hw] = l;   // renewed
		else if (l == '0) begin
			exp_acks = 1;   // bypass, single word
			exp_cycles = 1;
			if (r.we) begin
				ref_mem[r.addr] = r.wdata;
				exp_wr_addr.push_back(r.addr);
				exp_wr_data.push_back(r.wdata);
			end else
				exp_rdata = ref_mem[r.addr];
		end else begin
			// expired way first, else shorter lease, way 0 on a tie
			if (m_lease[s][0] == '0)
				v = 1'b0;
			else if (m_lease[s][1] == '0)
				v = 1'b1;
			else
				v = way_t'(m_lease[s][1] < m_lease[s][0]);
			exp_swap = 1'b1;
			m_lease[s][v] = l;
			if (m_valid[s][v] && m_dirty[s][v]) begin
				exp_wb = 1'b1;
				exp_acks += `LC_BLOCK_WORDS;
				exp_cycles++;
				for (int i = 0; i < `LC_BLOCK_WORDS; i++) begin
					a = {m_tag[s][v], s, offset_t'(i)};
					ref_mem[a] = m_line[s][v][i];
					exp_wr_addr.push_back(a);
					exp_wr_data.push_back(m_line[s][v][i]);
				end
			end
			exp_acks += `LC_BLOCK_WORDS;   // refill burst
			exp_cycles++;
			for (int i = 0; i < `LC_BLOCK_WORDS; i++)
				m_line[s][v][i] = ref_mem[{t, s, offset_t'(i)}];
			m_valid[s][v] = 1'b1;
			m_dirty[s][v] = 1'b0;
			m_tag[s][v] = t;
			in_line = 1'b1;   // replayed as a hit
			hw = v;
		end
		if (in_line && r.we) begin
			m_line[s][hw][o] = r.wdata;
			m_dirty[s][hw] = 1'b1;
		end else if (in_line)
			exp_rdata = m_line[s][hw][o];
	endtask

	// compare tasks
	// ----------------------------------------
	task automatic check_data(input string name, input logic [`LC_DATA_W-1:0] got, exp);
		if (got !== exp) begin
			mismatches++;
			$display("MISMATCH t=%0t req %0d %s: got %h expected %h", $time, cur_req, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, exp);
		if (got !== exp) begin
			mismatches++;
			$display("MISMATCH t=%0t req %0d %s: got %b expected %b", $time, cur_req, name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input word_addr_t got, exp);
		if (got !== exp) begin
			mismatches++;
			$display("MISMATCH t=%0t req %0d %s: got %h expected %h", $time, cur_req, name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, exp);
		if (got != exp) begin
			mismatches++;
			$display("MISMATCH t=%0t req %0d %s: got %0d expected %0d", $time, cur_req, name, got, exp);
		end
	endtask

	task automatic program_table();
		for (int i = 0; i < NUM_LLT; i++) begin
			@(posedge clock_i);
			llt_wren_i  <= 1'b1;
			llt_index_i <= llt_index_t'(i);
			llt_entry_i <= llt_tbl[i];
		end
		@(posedge clock_i);
		llt_wren_i <= 1'b0;
	endtask

	task automatic run_request(input int k);
		int   cycles;
		logic seen_hit;
		logic seen_miss;
		logic seen_wb;
		logic seen_swap;
		@(negedge clock_i);
		cur_req = k;
		n_acks = 0;
		n_cycles = 0;
		predict(stim[k]);
		@(posedge clock_i);
		core_req_i   <= 1'b1;
		core_we_i    <= stim[k].we;
		core_addr_i  <= stim[k].addr;
		core_wdata_i <= stim[k].wdata;
		cycles = 0;
		seen_hit = 1'b0;
		seen_miss = 1'b0;
		seen_wb = 1'b0;
		seen_swap = 1'b0;
		do begin
			@(posedge clock_i);
			cycles++;
			@(negedge clock_i);   // outputs settled
			seen_hit  |= flag_hit_o;
			seen_miss |= flag_miss_o;
			seen_wb   |= flag_writeback_o;
			seen_swap |= flag_swap_o;
		end while (core_done_o !== 1'b1 && cycles < TIMEOUT);
		if (core_done_o !== 1'b1) begin
			timeouts++;
			$display("request %0d got no core_done_o within %0d cycles", k, TIMEOUT);
		end else begin
			check_bit("core_hit_o", core_hit_o, exp_hit);
			check_bit("flag_hit_o", seen_hit, exp_hit);
			check_bit("flag_miss_o", seen_miss, !exp_hit);
			check_bit("flag_writeback_o", seen_wb, exp_wb);
			check_bit("flag_swap_o", seen_swap, exp_swap);
			if (!stim[k].we)
				check_data("core_rdata_o", core_rdata_o, exp_rdata);
			if (exp_hit)
				check_count("hit latency", cycles, 2);
			check_count("wishbone cycles", n_cycles, exp_cycles);
			check_count("wishbone acks", n_acks, exp_acks);
			check_count("wishbone writes", obs_wr_addr.size(), exp_wr_addr.size());
			for (int i = 0; i < obs_wr_addr.size() && i < exp_wr_addr.size(); i++) begin
				check_addr("wb_adr_o", obs_wr_addr[i], exp_wr_addr[i]);
				check_data("wb_dat_o", obs_wr_data[i], exp_wr_data[i]);
			end
		end
		obs_wr_addr.delete();
		obs_wr_data.delete();
		exp_wr_addr.delete();
		exp_wr_data.delete();
		@(posedge clock_i);
		core_req_i <= 1'b0;
	endtask

	// main sequence
	// ----------------------------------------
	initial begin
		void'($urandom(32'h3e8e_0c78));
		for (int i = 0; i < 256; i++)
			wait_tbl[i] = $urandom % 4;
		for (int a = 0; a < MEM_WORDS; a++) begin
			slave_mem[a] = fill_word(word_addr_t'(a));
			ref_mem[a]   = fill_word(word_addr_t'(a));
		end
		for (int s = 0; s < `LC_SETS; s++) begin
			for (int w = 0; w < `LC_WAYS; w++) begin
				m_valid[s][w] = 1'b0;   // all lines invalid, leases zero
				m_dirty[s][w] = 1'b0;
				m_tag[s][w]   = '0;
				m_lease[s][w] = '0;
			end
		end
		resetn_i     = 1'b0;
		core_req_i   = 1'b0;
		core_we_i    = 1'b0;
		core_addr_i  = '0;
		core_wdata_i = '0;
		llt_wren_i   = 1'b0;
		llt_index_i  = '0;
		llt_entry_i  = '0;
		repeat (8) @(posedge clock_i);
		resetn_i <= 1'b1;
		program_table();
		for (int k = 0; k < NUM_REQ; k++)
			if (timeouts == 0)
				run_request(k);
		$display("%0d mismatches, %0d timeouts", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: src/lease_cache_top.sv
`timescale 1ns/100ps
`include "lease_cache_settings.svh"

module lease_cache_top import cache_pkg::*; import lease_pkg::*; (
	input  logic                  clock_i,
	input  logic                  resetn_i,

	// core port
	input  logic                  core_req_i,
	input  logic                  core_we_i,
	input  word_addr_t            core_addr_i,
	input  logic [`LC_DATA_W-1:0] core_wdata_i,
	output logic [`LC_DATA_W-1:0] core_rdata_o,
	output logic                  core_done_o,
	output logic                  core_hit_o,

	// lease table programming
	input  logic                  llt_wren_i,
	input  llt_index_t            llt_index_i,
	input  llt_entry_t            llt_entry_i,

	// wishbone classic master
	output logic                  wb_cyc_o,
	output logic                  wb_stb_o,
	output logic                  wb_we_o,
	output word_addr_t            wb_adr_o,
	output logic [`LC_DATA_W-1:0] wb_dat_o,
	input  logic [`LC_DATA_W-1:0] wb_dat_i,
	input  logic                  wb_ack_i,

	output logic                  flag_hit_o,
	output logic                  flag_miss_o,
	output logic                  flag_writeback_o,
	output logic                  flag_swap_o
);

	set_t                  st_lookup_set;
	logic                  st_hit;
	way_t                  st_hit_way;
	logic [`LC_DATA_W-1:0] st_rd_data;
	tag_t                  st_victim_tag;
	logic                  st_victim_dirty;
	logic                  st_wr_en;
	way_t                  st_wr_way;
	offset_t               st_wr_offset;
	logic [`LC_DATA_W-1:0] st_wr_data;
	tag_t                  st_fill_tag;
	logic                  st_fill_done;
	logic                  st_set_dirty;
	tag_t                  core_tag;

	mem_xfer_if mem_bus ();
	lease_if    lease_bus ();

	assign core_tag = core_addr_i[`LC_ADDR_W-1 -: TAG_W];

	cache_controller i_ctrl (
		.clock_i          (clock_i),
		.resetn_i         (resetn_i),
		.core_req_i       (core_req_i),
		.core_we_i        (core_we_i),
		.core_addr_i      (core_addr_i),
		.core_wdata_i     (core_wdata_i),
		.core_rdata_o     (core_rdata_o),
		.core_done_o      (core_done_o),
		.core_hit_o       (core_hit_o),
		.lookup_set_o     (st_lookup_set),
		.hit_i            (st_hit),
		.hit_way_i        (st_hit_way),
		.rd_data_i        (st_rd_data),
		.victim_tag_i     (st_victim_tag),
		.victim_dirty_i   (st_victim_dirty),
		.wr_en_o          (st_wr_en),
		.wr_way_o         (st_wr_way),
		.wr_offset_o      (st_wr_offset),
		.wr_data_o        (st_wr_data),
		.fill_tag_o       (st_fill_tag),
		.fill_done_o      (st_fill_done),
		.set_dirty_o      (st_set_dirty),
		.lease_bus        (lease_bus.ctrl),
		.mem_bus          (mem_bus.ctrl),
		.flag_hit_o       (flag_hit_o),
		.flag_miss_o      (flag_miss_o),
		.flag_writeback_o (flag_writeback_o),
		.flag_swap_o      (flag_swap_o)
	);

	// read offset shares the controller's word select
	cache_store i_store (
		.clock_i         (clock_i),
		.resetn_i        (resetn_i),
		.lookup_set_i    (st_lookup_set),
		.lookup_tag_i    (core_tag),
		.lookup_offset_i (st_wr_offset),
		.hit_o           (st_hit),
		.hit_way_o       (st_hit_way),
		.rd_data_o       (st_rd_data),
		.victim_way_i    (lease_bus.victim_way),
		.victim_tag_o    (st_victim_tag),
		.victim_dirty_o  (st_victim_dirty),
		.wr_en_i         (st_wr_en),
		.wr_way_i        (st_wr_way),
		.wr_offset_i     (st_wr_offset),
		.wr_data_i       (st_wr_data),
		.fill_tag_i      (st_fill_tag),
		.fill_done_i     (st_fill_done),
		.set_dirty_i     (st_set_dirty)
	);

	lease_policy i_policy (
		.clock_i     (clock_i),
		.resetn_i    (resetn_i),
		.llt_wren_i  (llt_wren_i),
		.llt_index_i (llt_index_i),
		.llt_entry_i (llt_entry_i),
		.lease_bus   (lease_bus.policy)
	);

	wb_block_master i_wb (
		.clock_i  (clock_i),
		.resetn_i (resetn_i),
		.mem_bus  (mem_bus.master),
		.wb_cyc_o (wb_cyc_o),
		.wb_stb_o (wb_stb_o),
		.wb_we_o  (wb_we_o),
		.wb_adr_o (wb_adr_o),
		.wb_dat_o (wb_dat_o),
		.wb_dat_i (wb_dat_i),
		.wb_ack_i (wb_ack_i)
	);

endmodule

// File: src/wb_block_master.sv
`timescale 1ns/100ps
`include "lease_cache_settings.svh"

module wb_block_master import cache_pkg::*; (
	input  logic                  clock_i,
	input  logic                  resetn_i,
	mem_xfer_if.master            mem_bus,
	output logic                  wb_cyc_o,
	output logic                  wb_stb_o,
	output logic                  wb_we_o,
	output word_addr_t            wb_adr_o,
	output logic [`LC_DATA_W-1:0] wb_dat_o,
	input  logic [`LC_DATA_W-1:0] wb_dat_i,
	input  logic                  wb_ack_i
);

	offset_t beat_q;
	logic    is_block;
	logic    is_write;
	logic    last_beat;
	logic    launch;   // raise stb for the next word

	assign is_block  = (mem_bus.op == MOP_READ_BLOCK) || (mem_bus.op == MOP_WRITE_BLOCK);
	assign is_write  = (mem_bus.op == MOP_WRITE_BLOCK) || (mem_bus.op == MOP_WRITE_WORD);
	assign last_beat = !is_block || (beat_q == offset_t'(`LC_BLOCK_WORDS-1));

	// new command, or the idle cycle between words of a block
	assign launch = (!wb_cyc_o && mem_bus.req && !mem_bus.done) || (wb_cyc_o && !wb_stb_o);

	assign mem_bus.beat   = beat_q;
	assign mem_bus.rdata  = wb_dat_i;
	assign mem_bus.rvalid = wb_stb_o & wb_ack_i & ~wb_we_o;

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			wb_cyc_o     <= 1'b0;
			wb_stb_o     <= 1'b0;
			wb_we_o      <= 1'b0;
			beat_q       <= '0;
			mem_bus.done <= 1'b0;
		end else begin
			mem_bus.done <= 1'b0;
			if (launch) begin
				wb_cyc_o <= 1'b1;
				wb_stb_o <= 1'b1;
				wb_we_o  <= is_write;
			end else if (wb_stb_o && wb_ack_i) begin
				wb_stb_o <= 1'b0;
				if (last_beat) begin
					wb_cyc_o     <= 1'b0;
					wb_we_o      <= 1'b0;
					beat_q       <= '0;
					mem_bus.done <= 1'b1;
				end else
					beat_q <= beat_q + 1'b1;   // cyc stays up over the burst
			end
		end
	end

	// address and write data, wdata already follows beat_q
	always_ff @(posedge clock_i) begin
		if (launch) begin
			wb_adr_o <= mem_bus.addr + word_addr_t'(beat_q);
			wb_dat_o <= mem_bus.wdata;
		end
	end

	a_stb_in_cyc: assert property (@(posedge clock_i) disable iff (!resetn_i)
		wb_stb_o |-> wb_cyc_o);

endmodule

// File: cache_ctrl/cache_controller.sv
`timescale 1ns/100ps
`include "lease_cache_settings.svh"

module cache_controller import cache_pkg::*; import lease_pkg::*; (
	input  logic                  clock_i,
	input  logic                  resetn_i,

	// core port
	input  logic                  core_req_i,
	input  logic                  core_we_i,
	input  word_addr_t            core_addr_i,
	input  logic [`LC_DATA_W-1:0] core_wdata_i,
	output logic [`LC_DATA_W-1:0] core_rdata_o,
	output logic                  core_done_o,
	output logic                  core_hit_o,

	// cache store
	output set_t                  lookup_set_o,
	input  logic                  hit_i,
	input  way_t                  hit_way_i,
	input  logic [`LC_DATA_W-1:0] rd_data_i,
	input  tag_t                  victim_tag_i,
	input  logic                  victim_dirty_i,
	output logic                  wr_en_o,
	output way_t                  wr_way_o,
	output offset_t               wr_offset_o,     // also the store read offset
	output logic [`LC_DATA_W-1:0] wr_data_o,
	output tag_t                  fill_tag_o,
	output logic                  fill_done_o,
	output logic                  set_dirty_o,

	lease_if.ctrl                 lease_bus,
	mem_xfer_if.ctrl              mem_bus,

	// performance pulses
	output logic                  flag_hit_o,
	output logic                  flag_miss_o,
	output logic                  flag_writeback_o,
	output logic                  flag_swap_o
);

	ctrl_state_e state_q;
	logic        replay_q;   // request is back after a refill
	logic        start;
	logic        hit_wr;
	logic        refill_wr;
	tag_t        core_tag;
	set_t        core_set;
	offset_t     core_off;

	assign {core_tag, core_set, core_off} = core_addr_i;

	// core_done_o high means the held request is already answered
	assign start = core_req_i & ~core_done_o;

	// store access
	// ----------------------------------------
	assign hit_wr    = (state_q == ST_IDLE) && start && hit_i && core_we_i;
	assign refill_wr = (state_q == ST_REFILL) && mem_bus.rvalid;

	assign lookup_set_o = core_set;
	assign wr_en_o      = hit_wr | refill_wr;
	assign wr_way_o     = (state_q == ST_REFILL) ? lease_bus.victim_way : hit_way_i;
	assign wr_data_o    = (state_q == ST_REFILL) ? mem_bus.rdata : core_wdata_i;
	assign set_dirty_o  = hit_wr;                  // store hit, replay included
	assign fill_tag_o   = core_tag;
	assign fill_done_o  = (state_q == ST_REFILL) && mem_bus.done;

	// beat drives the offset while a block moves
	assign wr_offset_o = (state_q == ST_WRITEBACK || state_q == ST_REFILL) ?
		mem_bus.beat : core_off;

	// lease policy, the replay leaves leases alone
	// ----------------------------------------
	assign lease_bus.set        = core_set;
	assign lease_bus.hit_way    = hit_way_i;
	assign lease_bus.block_addr = {core_tag, core_set};

	always_comb begin
		lease_bus.op = LOP_NONE;
		if (state_q == ST_IDLE && start && !replay_q)
			lease_bus.op = hit_i ? LOP_HIT : LOP_MISS;
	end

	// memory commands, held by state until done
	// ----------------------------------------
	assign mem_bus.wdata = (state_q == ST_WRITEBACK) ? rd_data_i : core_wdata_i;

	always_comb begin
		mem_bus.req  = 1'b0;
		mem_bus.op   = MOP_READ_WORD;
		mem_bus.addr = core_addr_i;
		case (state_q)
			ST_WRITEBACK: begin
				mem_bus.req  = 1'b1;
				mem_bus.op   = MOP_WRITE_BLOCK;
				mem_bus.addr = {victim_tag_i, core_set, offset_t'(0)}; // old line base
			end
			ST_REFILL: begin
				mem_bus.req  = 1'b1;
				mem_bus.op   = MOP_READ_BLOCK;
				mem_bus.addr = {core_tag, core_set, offset_t'(0)};
			end
			ST_BYPASS: begin
				mem_bus.req = 1'b1;
				mem_bus.op  = core_we_i ? MOP_WRITE_WORD : MOP_READ_WORD;
			end
			default: ;
		endcase
	end

	// FSM
	// ----------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q          <= ST_IDLE;
			replay_q         <= 1'b0;
			core_done_o      <= 1'b0;
			core_hit_o       <= 1'b0;
			flag_hit_o       <= 1'b0;
			flag_miss_o      <= 1'b0;
			flag_writeback_o <= 1'b0;
			flag_swap_o      <= 1'b0;
		end else begin
			core_done_o      <= 1'b0;   // all pulses
			core_hit_o       <= 1'b0;
			flag_hit_o       <= 1'b0;
			flag_miss_o      <= 1'b0;
			flag_writeback_o <= 1'b0;
			flag_swap_o      <= 1'b0;
			case (state_q)
				ST_IDLE: begin
					if (start && hit_i) begin
						flag_hit_o <= ~replay_q;
						state_q    <= ST_RESPOND;
					end else if (start) begin
						flag_miss_o <= 1'b1;
						state_q     <= ST_LEASE_WAIT;
					end
				end
				ST_LEASE_WAIT: begin
					if (lease_bus.done) begin
						flag_swap_o <= lease_bus.swap;
						if (!lease_bus.swap)
							state_q <= ST_BYPASS;
						else if (victim_dirty_i) begin
							flag_writeback_o <= 1'b1;
							state_q          <= ST_WRITEBACK;
						end else
							state_q <= ST_REFILL;
					end
				end
				ST_WRITEBACK: if (mem_bus.done) state_q <= ST_REFILL;
				ST_REFILL: begin
					if (mem_bus.done) begin
						replay_q <= 1'b1;   // line is in, serve it as a hit
						state_q  <= ST_IDLE;
					end
				end
				ST_BYPASS: begin
					if (mem_bus.done) begin
						core_done_o <= 1'b1;
						state_q     <= ST_IDLE;
					end
				end
				ST_RESPOND: begin
					core_done_o <= 1'b1;
					core_hit_o  <= ~replay_q;
					replay_q    <= 1'b0;
					state_q     <= ST_IDLE;
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// read data, lines up with core_done_o
	always_ff @(posedge clock_i) begin
		if (state_q == ST_RESPOND)
			core_rdata_o <= rd_data_i;
		else if (state_q == ST_BYPASS && mem_bus.rvalid)
			core_rdata_o <= mem_bus.rdata;
	end

	// core request must not drop before it is answered
	a_core_req_held: assert property (@(posedge clock_i) disable iff (!resetn_i)
		core_req_i && !core_done_o |=> core_req_i);

	a_done_pulse: assert property (@(posedge clock_i) disable iff (!resetn_i)
		core_done_o |=> !core_done_o);

endmodule

// File: cache_ctrl/cache_store.sv
`timescale 1ns/100ps
`include "lease_cache_settings.svh"

module cache_store import cache_pkg::*; (
	input  logic                  clock_i,
	input  logic                  resetn_i,
	input  set_t                  lookup_set_i,
	input  tag_t                  lookup_tag_i,
	input  offset_t               lookup_offset_i,
	output logic                  hit_o,
	output way_t                  hit_way_o,
	output logic [`LC_DATA_W-1:0] rd_data_o,
	input  way_t                  victim_way_i,
	output tag_t                  victim_tag_o,
	output logic                  victim_dirty_o,
	input  logic                  wr_en_i,
	input  way_t                  wr_way_i,
	input  offset_t               wr_offset_i,
	input  logic [`LC_DATA_W-1:0] wr_data_i,
	input  tag_t                  fill_tag_i,
	input  logic                  fill_done_i,
	input  logic                  set_dirty_i
);

	tag_t                  tag_q   [`LC_WAYS][`LC_SETS];
	logic [`LC_WAYS-1:0]   valid_q [`LC_SETS];
	logic [`LC_WAYS-1:0]   dirty_q [`LC_SETS];
	logic [`LC_DATA_W-1:0] data_q  [`LC_WAYS][`LC_SETS][`LC_BLOCK_WORDS];
	logic [`LC_WAYS-1:0]   way_match;
	way_t                  rd_way;

	// two-way compare
	always_comb begin
		for (int w = 0; w < `LC_WAYS; w++)
			way_match[w] = valid_q[lookup_set_i][w] && (tag_q[w][lookup_set_i] == lookup_tag_i);
	end

	assign hit_o     = |way_match;
	assign hit_way_o = way_match[1];

	// on a miss the read port follows the victim, for writeback
	assign rd_way         = hit_o ? hit_way_o : victim_way_i;
	assign rd_data_o      = data_q[rd_way][lookup_set_i][lookup_offset_i];
	assign victim_tag_o   = tag_q[victim_way_i][lookup_set_i];
	assign victim_dirty_o = valid_q[lookup_set_i][victim_way_i] & dirty_q[lookup_set_i][victim_way_i];

	// line state
	// ----------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			for (int s = 0; s < `LC_SETS; s++) begin
				valid_q[s] <= '0;
				dirty_q[s] <= '0;
			end
		end else if (fill_done_i) begin
			valid_q[lookup_set_i][wr_way_i] <= 1'b1;
			dirty_q[lookup_set_i][wr_way_i] <= 1'b0;   // fresh copy of memory
		end else if (wr_en_i && set_dirty_i)
			dirty_q[lookup_set_i][wr_way_i] <= 1'b1;
	end

	always_ff @(posedge clock_i) begin
		if (fill_done_i)
			tag_q[wr_way_i][lookup_set_i] <= fill_tag_i;
		if (wr_en_i)
			data_q[wr_way_i][lookup_set_i][wr_offset_i] <= wr_data_i;
	end

endmodule

// File: lease/lease_policy.sv
`timescale 1ns/100ps
`include "lease_cache_settings.svh"

module lease_policy import cache_pkg::*; import lease_pkg::*; (
	input  logic       clock_i,
	input  logic       resetn_i,
	input  logic       llt_wren_i,
	input  llt_index_t llt_index_i,
	input  llt_entry_t llt_entry_i,
	lease_if.policy    lease_bus
);

	lease_t lease_q [`LC_SETS][`LC_WAYS];   // remaining lease per line
	lease_t llt_lease;                      // lookup result, one cycle late
	logic   hit_q;
	logic   miss_q;
	set_t   set_q;
	way_t   way_q;
	way_t   victim;

	lease_lookup_table i_llt (
		.clock_i       (clock_i),
		.resetn_i      (resetn_i),
		.wren_i        (llt_wren_i),
		.index_i       (llt_index_i),
		.entry_i       (llt_entry_i),
		.search_addr_i (lease_bus.block_addr),
		.lease_o       (llt_lease)
	);

	// expired way first, else the shorter lease, way 0 on a tie
	assign victim = (lease_q[set_q][0] == '0) ? 1'b0 :
		(lease_q[set_q][1] == '0) ? 1'b1 : (lease_q[set_q][1] < lease_q[set_q][0]);

	always_ff @(posedge clock_i) begin
		set_q <= lease_bus.set;
		way_q <= lease_bus.hit_way;
	end

	// lease counting
	// ----------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			for (int s = 0; s < `LC_SETS; s++)
				for (int w = 0; w < `LC_WAYS; w++)
					lease_q[s][w] <= '0;
			hit_q                <= 1'b0;
			miss_q               <= 1'b0;
			lease_bus.done       <= 1'b0;
			lease_bus.swap       <= 1'b0;
			lease_bus.victim_way <= 1'b0;
		end else begin
			hit_q          <= (lease_bus.op == LOP_HIT);
			miss_q         <= (lease_bus.op == LOP_MISS);
			lease_bus.done <= miss_q;
			// age every other line of the set, saturating at zero
			if (lease_bus.op != LOP_NONE) begin
				for (int w = 0; w < `LC_WAYS; w++) begin
					if ((lease_bus.op == LOP_MISS || way_t'(w) != lease_bus.hit_way) &&
							lease_q[lease_bus.set][w] != '0)
						lease_q[lease_bus.set][w] <= lease_q[lease_bus.set][w] - 1'b1;
				end
			end
			if (hit_q)
				lease_q[set_q][way_q] <= llt_lease;   // renew from table
			if (miss_q) begin
				lease_bus.victim_way <= victim;
				lease_bus.swap       <= (llt_lease != '0);
				if (llt_lease != '0)
					lease_q[set_q][victim] <= llt_lease;
			end
		end
	end

	// miss answer comes exactly two cycles after the request
	a_done_latency: assert property (@(posedge clock_i) disable iff (!resetn_i)
		lease_bus.done |-> $past(lease_bus.op, 2) == LOP_MISS);

endmodule

// File: lease/lease_lookup_table.sv
`timescale 1ns/100ps
`include "lease_cache_settings.svh"

module lease_lookup_table import lease_pkg::*; (
	input  logic        clock_i,
	input  logic        resetn_i,
	input  logic        wren_i,
	input  llt_index_t  index_i,
	input  llt_entry_t  entry_i,
	input  block_addr_t search_addr_i,
	output lease_t      lease_o
);

	llt_entry_t                entry_q [`LC_LLT_ENTRIES];
	logic [`LC_LLT_ENTRIES-1:0] valid_q;
	lease_t                    match_lease;

	// associative search, walk down so the lowest match wins
	always_comb begin
		match_lease = '0;   // not in table means bypass
		for (int i = `LC_LLT_ENTRIES-1; i >= 0; i--) begin
			if (valid_q[i] && entry_q[i].block_addr == search_addr_i)
				match_lease = entry_q[i].lease;
		end
	end

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			valid_q <= '0;
			lease_o <= '0;
		end else begin
			lease_o <= match_lease;
			if (wren_i)
				valid_q[index_i] <= 1'b1;
		end
	end

	always_ff @(posedge clock_i) begin
		if (wren_i)
			entry_q[index_i] <= entry_i;
	end

endmodule

// File: common/lease_if.sv
`timescale 1ns/100ps

// controller <-> lease policy
interface lease_if import cache_pkg::*; import lease_pkg::*; ();

	lease_op_e   op;          // single cycle strobe
	set_t        set;
	way_t        hit_way;     // only meaningful with LOP_HIT
	block_addr_t block_addr;  // table search key

	// miss answer, two cycles after LOP_MISS
	logic        done;
	way_t        victim_way;  // held until the next miss
	logic        swap;        // missed block gets cached

	modport ctrl (
		output op, set, hit_way, block_addr,
		input  done, victim_way, swap
	);

	modport policy (
		input  op, set, hit_way, block_addr,
		output done, victim_way, swap
	);

endinterface

// File: common/mem_xfer_if.sv
`timescale 1ns/100ps
`include "lease_cache_settings.svh"

// controller <-> wishbone master command channel
interface mem_xfer_if import cache_pkg::*; ();

	logic                  req;     // held until done
	mem_op_e               op;
	word_addr_t            addr;    // block base on block ops
	logic [`LC_DATA_W-1:0] wdata;   // sampled per beat on writes

	offset_t               beat;    // current word of the transfer
	logic [`LC_DATA_W-1:0] rdata;
	logic                  rvalid;  // one pulse per returned word
	logic                  done;    // one cycle after the last ack

	modport ctrl (
		output req, op, addr, wdata,
		input  beat, rdata, rvalid, done
	);

	modport master (
		input  req, op, addr, wdata,
		output beat, rdata, rvalid, done
	);

endinterface

// File: common/lease_pkg.sv
`include "lease_cache_settings.svh"

package lease_pkg;

	typedef logic [`LC_LEASE_W-1:0] lease_t;   // remaining lease of a line

	// word address without the block offset
	typedef logic [`LC_ADDR_W-$clog2(`LC_BLOCK_WORDS)-1:0] block_addr_t;
	typedef logic [$clog2(`LC_LLT_ENTRIES)-1:0]            llt_index_t;

	typedef struct packed {
		block_addr_t block_addr;
		lease_t      lease;       // zero means bypass
	} llt_entry_t;

	typedef enum logic [1:0] {
		LOP_NONE,
		LOP_HIT,   // age the set, renew the hit line
		LOP_MISS   // age the set, pick victim and swap
	} lease_op_e;

endpackage

// File: common/cache_pkg.sv
`include "lease_cache_settings.svh"

package cache_pkg;

	// word address split
	// ----------------------------------------
	localparam int OFFSET_W = $clog2(`LC_BLOCK_WORDS);
	localparam int SET_W    = $clog2(`LC_SETS);
	localparam int TAG_W    = `LC_ADDR_W - SET_W - OFFSET_W;

	typedef logic [`LC_ADDR_W-1:0] word_addr_t;    // {tag, set, offset}
	typedef logic [TAG_W-1:0]      tag_t;
	typedef logic [SET_W-1:0]      set_t;
	typedef logic [OFFSET_W-1:0]   offset_t;       // word within block
	typedef logic                  way_t;          // two ways

	// controller sequencing
	// ----------------------------------------
	typedef enum logic [2:0] {
		ST_IDLE,        // sample request, hit check
		ST_LEASE_WAIT,  // miss, waiting on victim and swap
		ST_WRITEBACK,   // dirty victim out to memory
		ST_REFILL,      // block burst into victim way
		ST_BYPASS,      // single word, nothing cached
		ST_RESPOND      // hit answer to the core
	} ctrl_state_e;

	// memory commands to the wishbone master
	typedef enum logic [1:0] {
		MOP_READ_BLOCK,
		MOP_WRITE_BLOCK,
		MOP_READ_WORD,
		MOP_WRITE_WORD
	} mem_op_e;

endpackage

// File: common/lease_cache_settings.svh
`ifndef LEASE_CACHE_SETTINGS_SVH
`define LEASE_CACHE_SETTINGS_SVH

// address and data widths
`define LC_ADDR_W       16  // word address
`define LC_DATA_W       32

// cache geometry
`define LC_BLOCK_WORDS  4   // words per block, one burst
`define LC_SETS         8
`define LC_WAYS         2   // way_t is a single bit

// lease hardware
`define LC_LLT_ENTRIES  8   // lookup table depth
`define LC_LEASE_W      8   // remaining-lease counter

`endif
